// ==== hw/periph_cfg.svh ====
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define PERIPH_ADDR_W        32
`define PERIPH_DATA_W        32
`define PERIPH_BE_W          4

// Width of the LED and DIP switch pins
`define PERIPH_GPIO_W        8

// ----------------------------------------
// Storage sizes
// ----------------------------------------
`define PERIPH_QUEUE_DEPTH   4     // Pending commands
`define PERIPH_RAM_WORDS     256   // Boot RAM words

// ----------------------------------------
// Address map
// ----------------------------------------
// Upper 20 bits of the address select a 4 KiB page
`define PERIPH_BOOT_PAGE     20'h00010
`define PERIPH_GPIO_PAGE     20'h40000

// Read value for unmapped space and undefined registers
`define PERIPH_ERR_WORD      32'hDEADBEEF

`endif

// ==== hw/periph_bus_pkg.sv ====
`include "periph_cfg.svh"

package periph_bus_pkg;

    // ----------------------------------------
    // Command as held in the queue
    // ----------------------------------------
    // we + addr + be + wdata = 1 + 32 + 4 + 32 = 69 bits
    typedef struct packed {
        logic                       we;     // 1 for write
        logic [`PERIPH_ADDR_W-1:0]  addr;   // Byte address
        logic [`PERIPH_BE_W-1:0]    be;     // One bit per byte lane
        logic [`PERIPH_DATA_W-1:0]  wdata;
    } periph_cmd_t;

    // ----------------------------------------
    // Response back to the host
    // ----------------------------------------
    // rdata + err = 32 + 1 = 33 bits
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0]  rdata;  // Zero for writes
        logic                       err;    // Unmapped access
    } periph_rsp_t;

    localparam int PERIPH_CMD_W = $bits(periph_cmd_t);
    localparam int PERIPH_RSP_W = $bits(periph_rsp_t);

    // Clear response, used after reset
    localparam periph_rsp_t PERIPH_RSP_IDLE = '{
        rdata: '0,
        err:   1'b0
    };

endpackage

// ==== hw/periph_map_pkg.sv ====
`include "periph_cfg.svh"

package periph_map_pkg;

    // Two decodes of the same address word
    typedef union packed {
        struct packed {
            logic [19:0] page;      // Region select
            logic [11:0] offset;    // Byte offset in the page
        } map_view;
        struct packed {
            logic [25:0] high;
            logic [2:0]  reg_sel;   // GPIO register, bits 5..3
            logic [2:0]  lane;      // Byte within the 64-bit slot
        } reg_view;
    } periph_addr_u;

    typedef enum logic [1:0] {
        REGION_BOOT = 2'd0,
        REGION_GPIO = 2'd1,
        REGION_NONE = 2'd2
    } region_e;

    // Only register 0 exists in this GPIO page
    typedef enum logic [2:0] {
        GPIO_IO = 3'd0
    } gpio_reg_e;

    function automatic region_e page_to_region(input logic [19:0] page);
        case (page)
            `PERIPH_BOOT_PAGE: return REGION_BOOT;
            `PERIPH_GPIO_PAGE: return REGION_GPIO;
            default:           return REGION_NONE;
        endcase
    endfunction

endpackage

// ==== hw/boot_ram.sv ====
`timescale 1ns/1ps
`include "periph_cfg.svh"

module boot_ram (
    input  logic                                clk_i,
    input  logic                                en_i,
    input  logic                                we_i,
    input  logic [$clog2(`PERIPH_RAM_WORDS)-1:0] word_i,
    input  logic [`PERIPH_BE_W-1:0]             be_i,
    input  logic [`PERIPH_DATA_W-1:0]           wdata_i,
    output logic [`PERIPH_DATA_W-1:0]           rdata_o
);

    logic [`PERIPH_DATA_W-1:0] mem [`PERIPH_RAM_WORDS];

    // ----------------------------------------
    // Single port, one cycle read latency
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (en_i)
        begin
            if (we_i)
            begin
                for (int b = 0; b < `PERIPH_BE_W; b++)
                begin
                    if (be_i[b])
                        mem[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];   // Enabled bytes only
                end
            end
            rdata_o <= mem[word_i];    // Old data on a write
        end
    end

endmodule

// ==== hw/cmd_queue.sv ====
`timescale 1ns/1ps
`include "periph_cfg.svh"

module cmd_queue (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        push_i,
    input  periph_bus_pkg::periph_cmd_t push_cmd_i,
    input  logic                        pop_i,
    output logic                        full_o,
    output logic                        empty_o,
    output periph_bus_pkg::periph_cmd_t head_cmd_o
);

    import periph_bus_pkg::*;

    localparam int DEPTH = `PERIPH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    periph_cmd_t        mem [DEPTH];        // Entry storage
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;            // 0 .. DEPTH

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (push_i)
            mem[wr_ptr_q] <= push_cmd_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at DEPTH
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // Simultaneous push and pop leave the count alone
            if (push_i && !pop_i)
                count_q <= count_q + 1'b1;
            else if (pop_i && !push_i)
                count_q <= count_q - 1'b1;
        end
    end

    assign full_o     = (count_q == (PTR_W+1)'(DEPTH));
    assign empty_o    = (count_q == '0);
    assign head_cmd_o = mem[rd_ptr_q];

    // The host port and the targets must respect the flags
    no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i |-> !full_o);
    no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_i |-> !empty_o);

endmodule

// ==== hw/host_port.sv ====
`timescale 1ns/1ps
`include "periph_cfg.svh"

module host_port (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        cmd_req_i,
    input  logic                        cmd_we_i,
    input  logic [`PERIPH_ADDR_W-1:0]   cmd_addr_i,
    input  logic [`PERIPH_BE_W-1:0]     cmd_be_i,
    input  logic [`PERIPH_DATA_W-1:0]   cmd_wdata_i,
    input  logic                        full_i,
    output logic                        cmd_ack_o,
    output logic                        push_o,
    output periph_bus_pkg::periph_cmd_t push_cmd_o
);

    // ----------------------------------------
    // Four-phase command handshake
    // ----------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE,        // Waiting for a new request
        ST_ACKED,       // First cycle with ack high
        ST_WAIT_LOW     // Ack held until req drops
    } phase_e;

    phase_e state_q;
    phase_e state_d;

    always_comb
    begin
        state_d = state_q;
        push_o  = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                // A full queue holds off the ack
                if (cmd_req_i && !full_i)
                begin
                    push_o  = 1'b1;
                    state_d = ST_ACKED;
                end
            end
            ST_ACKED:
            begin
                state_d = cmd_req_i ? ST_WAIT_LOW : ST_IDLE;
            end
            ST_WAIT_LOW:
            begin
                if (!cmd_req_i)
                    state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    assign cmd_ack_o = (state_q != ST_IDLE);

    // Fields are stable while req is high
    assign push_cmd_o.we    = cmd_we_i;
    assign push_cmd_o.addr  = cmd_addr_i;
    assign push_cmd_o.be    = cmd_be_i;
    assign push_cmd_o.wdata = cmd_wdata_i;

    // Ack only ever answers a request seen on the cycle before
    ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cmd_ack_o) |-> $past(cmd_req_i));

endmodule

// ==== hw/periph_targets.sv ====
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_targets (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        empty_i,
    input  periph_bus_pkg::periph_cmd_t head_cmd_i,
    input  logic                        rsp_ack_i,
    input  logic [`PERIPH_GPIO_W-1:0]   dip_switches_i,
    output logic                        pop_o,
    output logic                        rsp_req_o,
    output logic [`PERIPH_DATA_W-1:0]   rsp_rdata_o,
    output logic                        rsp_err_o,
    output logic [`PERIPH_GPIO_W-1:0]   leds_o
);

    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,        // Pop when the queue has work
        ST_ACCESS,      // RAM data arrives, response is built
        ST_RESP,        // rsp_req_o high
        ST_DROP         // Wait for rsp_ack_i low
    } state_e;

    state_e                     state_q;
    periph_addr_u               head_addr;
    region_e                    head_region;
    logic                       op_we_q;
    region_e                    op_region_q;
    gpio_reg_e                  op_reg_q;
    logic [`PERIPH_DATA_W-1:0]  ram_rdata;
    periph_rsp_t                rsp_next;
    periph_rsp_t                rsp_q;
    logic [`PERIPH_GPIO_W-1:0]  leds_q;

    // ----------------------------------------
    // Decode of the queue head
    // ----------------------------------------
    assign head_addr   = head_cmd_i.addr;
    assign head_region = page_to_region(head_addr.map_view.page);
    assign pop_o       = (state_q == ST_IDLE) && !empty_i;

    boot_ram u_boot_ram (
        .clk_i   (clk_i),
        .en_i    (pop_o && (head_region == REGION_BOOT)),
        .we_i    (head_cmd_i.we),
        .word_i  (head_addr.map_view.offset[9:2]),
        .be_i    (head_cmd_i.be),
        .wdata_i (head_cmd_i.wdata),
        .rdata_o (ram_rdata)
    );

    // Operation details kept for the access cycle
    always_ff @(posedge clk_i)
    begin
        if (pop_o)
        begin
            op_we_q     <= head_cmd_i.we;
            op_region_q <= head_region;
            op_reg_q    <= gpio_reg_e'(head_addr.reg_view.reg_sel);
        end
    end

    // LED register, written on the pop cycle
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            leds_q <= '0;
        else if (pop_o && head_cmd_i.we && head_region == REGION_GPIO &&
                 gpio_reg_e'(head_addr.reg_view.reg_sel) == GPIO_IO && head_cmd_i.be[0])
            leds_q <= head_cmd_i.wdata[`PERIPH_GPIO_W-1:0];
    end

    assign leds_o = leds_q;

    // ----------------------------------------
    // Response
    // ----------------------------------------
    always_comb
    begin
        rsp_next.err = (op_region_q == REGION_NONE);
        if (op_we_q)
            rsp_next.rdata = '0;
        else
        begin
            case (op_region_q)
                REGION_BOOT: rsp_next.rdata = ram_rdata;
                REGION_GPIO: rsp_next.rdata = (op_reg_q == GPIO_IO) ?
                    {{(`PERIPH_DATA_W-`PERIPH_GPIO_W){1'b0}}, dip_switches_i} :
                    `PERIPH_ERR_WORD;                           // Undefined, not an error
                default:     rsp_next.rdata = `PERIPH_ERR_WORD;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            state_q <= ST_IDLE;
            rsp_q   <= PERIPH_RSP_IDLE;
        end
        else
        begin
            case (state_q)
                ST_IDLE:   if (pop_o) state_q <= ST_ACCESS;
                ST_ACCESS:
                begin
                    rsp_q   <= rsp_next;    // Frozen until the next access
                    state_q <= ST_RESP;
                end
                ST_RESP:   if (rsp_ack_i) state_q <= ST_DROP;
                ST_DROP:   if (!rsp_ack_i) state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    assign rsp_req_o   = (state_q == ST_RESP);
    assign rsp_rdata_o = rsp_q.rdata;
    assign rsp_err_o   = rsp_q.err;

    // Host sees steady data until it acknowledges
    rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_req_o && !rsp_ack_i |=> rsp_req_o && $stable(rsp_rdata_o) && $stable(rsp_err_o));

endmodule

// ==== hw/periph_subsys.sv ====
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_subsys (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Command handshake
    input  logic                        cmd_req_i,
    input  logic                        cmd_we_i,
    input  logic [`PERIPH_ADDR_W-1:0]   cmd_addr_i,
    input  logic [`PERIPH_BE_W-1:0]     cmd_be_i,
    input  logic [`PERIPH_DATA_W-1:0]   cmd_wdata_i,
    output logic                        cmd_ack_o,
    // Response handshake
    output logic                        rsp_req_o,
    output logic [`PERIPH_DATA_W-1:0]   rsp_rdata_o,
    output logic                        rsp_err_o,
    input  logic                        rsp_ack_i,
    // GPIO pins
    output logic [`PERIPH_GPIO_W-1:0]   leds_o,
    input  logic [`PERIPH_GPIO_W-1:0]   dip_switches_i
);

    import periph_bus_pkg::*;

    logic        push;
    logic        pop;
    logic        full;
    logic        empty;
    periph_cmd_t push_cmd;
    periph_cmd_t head_cmd;

    host_port u_host_port (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_req_i   (cmd_req_i),
        .cmd_we_i    (cmd_we_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_be_i    (cmd_be_i),
        .cmd_wdata_i (cmd_wdata_i),
        .full_i      (full),
        .cmd_ack_o   (cmd_ack_o),
        .push_o      (push),
        .push_cmd_o  (push_cmd)
    );

    cmd_queue u_cmd_queue (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .push_i     (push),
        .push_cmd_i (push_cmd),
        .pop_i      (pop),
        .full_o     (full),
        .empty_o    (empty),
        .head_cmd_o (head_cmd)
    );

    // In-order single consumer, so responses follow command order
    periph_targets u_periph_targets (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .empty_i        (empty),
        .head_cmd_i     (head_cmd),
        .rsp_ack_i      (rsp_ack_i),
        .dip_switches_i (dip_switches_i),
        .pop_o          (pop),
        .rsp_req_o      (rsp_req_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_err_o      (rsp_err_o),
        .leds_o         (leds_o)
    );

endmodule

// ==== tests/tb_periph_subsys.sv ====
`timescale 1ns/1ps
`include "periph_cfg.svh"

module tb_periph_subsys;

    localparam int ACK_TIMEOUT   = 200;     // Cycles per handshake phase
    localparam int DRAIN_TIMEOUT = 2000;

    logic                       clk_i = 1'b0;
    logic                       reset_i;
    logic                       cmd_req_i;
    logic                       cmd_we_i;
    logic [`PERIPH_ADDR_W-1:0]  cmd_addr_i;
    logic [`PERIPH_BE_W-1:0]    cmd_be_i;
    logic [`PERIPH_DATA_W-1:0]  cmd_wdata_i;
    logic                       cmd_ack_o;
    logic                       rsp_req_o;
    logic [`PERIPH_DATA_W-1:0]  rsp_rdata_o;
    logic                       rsp_err_o;
    logic                       rsp_ack_i;
    logic [`PERIPH_GPIO_W-1:0]  leds_o;
    logic [`PERIPH_GPIO_W-1:0]  dip_switches_i;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    integer      seed;
    logic [31:0] ram_shadow [`PERIPH_RAM_WORDS];
    logic [7:0]  led_shadow;
    logic [31:0] exp_rdata [256];   // Expected responses, ring with 8-bit pointers
    logic        exp_err   [256];
    logic [7:0]  exp_leds  [256];   // LED state once that command is done
    int          exp_delay [256];   // Ack delay for that response
    logic [7:0]  wr_ptr;
    logic [7:0]  rd_ptr;
    int          cmd_cnt;
    int          rsp_cnt;
    int          ack_min;
    int          ack_wait;
    int          stall_cycles;
    int          mismatch_cnt = 0;
    int          fail_cnt;
    logic [31:0] head_rdata;
    logic        head_err;
    logic [7:0]  head_leds;

    periph_subsys dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .cmd_req_i      (cmd_req_i),
        .cmd_we_i       (cmd_we_i),
        .cmd_addr_i     (cmd_addr_i),
        .cmd_be_i       (cmd_be_i),
        .cmd_wdata_i    (cmd_wdata_i),
        .cmd_ack_o      (cmd_ack_o),
        .rsp_req_o      (rsp_req_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_err_o      (rsp_err_o),
        .rsp_ack_i      (rsp_ack_i),
        .leds_o         (leds_o),
        .dip_switches_i (dip_switches_i)
    );

    always #5 clk_i = ~clk_i;

    assign head_rdata = exp_rdata[rd_ptr];
    assign head_err   = exp_err[rd_ptr];
    assign head_leds  = exp_leds[rd_ptr];

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    reset_state_check: assert property (@(posedge clk_i)
        $past(reset_i) |-> !cmd_ack_o && !rsp_req_o && leds_o == '0)
    else
    begin
        mismatch_cnt++;
        $display("mismatch after reset: cmd_ack_o=%h rsp_req_o=%h leds_o=%h, expected 0",
                 $sampled(cmd_ack_o), $sampled(rsp_req_o), $sampled(leds_o));
    end

    rsp_count_check: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(rsp_req_o) |-> rsp_cnt < cmd_cnt)
    else
    begin
        mismatch_cnt++;
        $display("response arrived with no command outstanding");
    end

    rsp_rdata_check: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(rsp_req_o) |-> rsp_rdata_o == head_rdata)
    else
    begin
        mismatch_cnt++;
        $display("mismatch rsp_rdata_o: got %h expected %h (response %0d)",
                 $sampled(rsp_rdata_o), $sampled(head_rdata), rsp_cnt);
    end

    rsp_err_check: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(rsp_req_o) |-> rsp_err_o == head_err)
    else
    begin
        mismatch_cnt++;
        $display("mismatch rsp_err_o: got %h expected %h (response %0d)",
                 $sampled(rsp_err_o), $sampled(head_err), rsp_cnt);
    end

    // LEDs already updated when the response is raised
    leds_check: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(rsp_req_o) |-> leds_o == head_leds)
    else
    begin
        mismatch_cnt++;
        $display("mismatch leds_o: got %h expected %h (response %0d)",
                 $sampled(leds_o), $sampled(head_leds), rsp_cnt);
    end

    ack_stall_check: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_req_i && !cmd_ack_o && dut.u_cmd_queue.full_o |=> !cmd_ack_o)
    else
    begin
        mismatch_cnt++;
        $display("cmd_ack_o rose while the command queue was full");
    end

    always @(posedge clk_i)
    begin
        if (reset_i)
            stall_cycles <= 0;
        else if (cmd_req_i && !cmd_ack_o && dut.u_cmd_queue.full_o)
            stall_cycles <= stall_cycles + 1;
    end

    // Response side of the host, ack after the delay stored per command
    initial
    begin
        rsp_ack_i = 1'b0;
        rd_ptr    = '0;
        rsp_cnt   = 0;
        ack_wait  = 0;
        forever
        begin
            @(posedge clk_i);
            #1;
            if (rsp_req_o && !rsp_ack_i)
            begin
                if (ack_wait >= exp_delay[rd_ptr])
                    rsp_ack_i = 1'b1;
                else
                    ack_wait++;
            end
            else if (!rsp_req_o && rsp_ack_i)
            begin
                rsp_ack_i = 1'b0;   // Response done
                ack_wait  = 0;
                rd_ptr++;
                rsp_cnt++;
            end
        end
    end

    // ----------------------------------------
    // Reference model and host tasks
    // ----------------------------------------
    task automatic model_cmd(input logic we, input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        logic [31:0] r;
        int          b;
        rdata = 32'h0;
        err   = 1'b0;
        r     = $random(seed);
        if (addr[31:12] == `PERIPH_BOOT_PAGE)
        begin
            if (we)
            begin
                for (b = 0; b < 4; b++)
                    if (be[b])
                        ram_shadow[addr[9:2]][b*8 +: 8] = wdata[b*8 +: 8];
            end
            else
                rdata = ram_shadow[addr[9:2]];
        end
        else if (addr[31:12] == `PERIPH_GPIO_PAGE)
        begin
            if (addr[5:3] != 3'd0)
                rdata = we ? 32'h0 : `PERIPH_ERR_WORD;    // Undefined register
            else if (!we)
                rdata = {24'h0, dip_switches_i};
            else if (be[0])
                led_shadow = wdata[7:0];
        end
        else
        begin
            err   = 1'b1;
            rdata = we ? 32'h0 : `PERIPH_ERR_WORD;
        end
        exp_rdata[wr_ptr] = rdata;
        exp_err[wr_ptr]   = err;
        exp_leds[wr_ptr]  = led_shadow;
        exp_delay[wr_ptr] = ack_min + int'(r[1:0]);
        wr_ptr++;
        cmd_cnt++;
    endtask

    task automatic send_cmd(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
        int waited;
        model_cmd(we, addr, be, wdata);
        cmd_we_i    = we;
        cmd_addr_i  = addr;
        cmd_be_i    = be;
        cmd_wdata_i = wdata;
        cmd_req_i   = 1'b1;
        waited      = 0;
        while (!cmd_ack_o && waited < ACK_TIMEOUT)
        begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!cmd_ack_o)
        begin
            fail_cnt++;
            $display("timeout waiting for cmd_ack_o to rise, address %h", addr);
        end
        cmd_req_i = 1'b0;
        waited    = 0;
        while (cmd_ack_o && waited < ACK_TIMEOUT)
        begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (cmd_ack_o)
        begin
            fail_cnt++;
            $display("timeout waiting for cmd_ack_o to fall, address %h", addr);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (rsp_cnt != cmd_cnt && waited < DRAIN_TIMEOUT)
        begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (rsp_cnt != cmd_cnt)
        begin
            fail_cnt++;
            $display("timeout: only %0d of %0d responses came back", rsp_cnt, cmd_cnt);
        end
    endtask

    function automatic logic [31:0] ram_addr(input logic [7:0] word);
        logic [31:0] r;
        r = $random(seed);
        return {`PERIPH_BOOT_PAGE, r[11:10], word, r[1:0]};
    endfunction

    function automatic logic [31:0] gpio_addr(input logic [2:0] sel);
        logic [31:0] r;
        r = $random(seed);
        return {`PERIPH_GPIO_PAGE, r[11:6], sel, r[2:0]};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[31:12] == `PERIPH_BOOT_PAGE || r[31:12] == `PERIPH_GPIO_PAGE)
            r[12] = ~r[12];     // Step off the mapped page
        return r;
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [2:0]  sel;
        int          i;
        seed           = 32'h7b52_cef7;
        reset_i        = 1'b1;
        cmd_req_i      = 1'b0;
        cmd_we_i       = 1'b0;
        cmd_addr_i     = '0;
        cmd_be_i       = '0;
        cmd_wdata_i    = '0;
        dip_switches_i = '0;
        led_shadow     = '0;
        wr_ptr         = '0;
        cmd_cnt        = 0;
        fail_cnt       = 0;
        ack_min        = 0;
        repeat (8) @(posedge clk_i);
        #1;
        reset_i        = 1'b0;
        r              = $random(seed);
        dip_switches_i = r[7:0];

        // Boot RAM, words 0..15 filled first so every byte is known
        for (i = 0; i < 16; i++)
            send_cmd(1'b1, ram_addr(8'(i)), 4'hF, $random(seed));
        for (i = 0; i < 24; i++)
        begin
            r = $random(seed);
            send_cmd(1'b1, ram_addr({4'h0, r[3:0]}), r[7:4], $random(seed));
            send_cmd(1'b0, ram_addr({4'h0, r[3:0]}), r[11:8], 32'h0);
        end
        drain();

        // GPIO page
        r              = $random(seed);
        dip_switches_i = r[15:8];
        for (i = 0; i < 4; i++)
        begin
            r   = $random(seed);
            sel = (r[10:8] == 3'd0) ? 3'd7 : r[10:8];
            send_cmd(1'b1, gpio_addr(3'd0), r[3:0] | 4'h1, $random(seed));
            send_cmd(1'b1, gpio_addr(3'd0), r[7:4] & 4'hE, $random(seed));   // LEDs hold
            send_cmd(1'b0, gpio_addr(3'd0), 4'hF, 32'h0);
            send_cmd(1'b0, gpio_addr(sel), 4'hF, 32'h0);
            send_cmd(1'b1, gpio_addr(sel), 4'hF, $random(seed));
        end
        drain();

        // Unmapped pages
        for (i = 0; i < 8; i++)
        begin
            r = $random(seed);
            send_cmd(r[0], unmapped_addr(), r[7:4], $random(seed));
        end
        drain();

        // Back-pressure, slow response acks fill the queue
        ack_min = 16;
        for (i = 0; i < 32; i++)
        begin
            r = $random(seed);
            case (r[1:0])
                2'd2:    addr = gpio_addr(r[4:2]);
                2'd3:    addr = unmapped_addr();
                default: addr = ram_addr({4'h0, r[7:4]});
            endcase
            send_cmd(r[8], addr, r[12:9], $random(seed));
        end
        drain();
        ack_min = 0;

        assert (stall_cycles > 0)
        else
        begin
            fail_cnt++;
            $display("command queue never filled, ack stall not reached");
        end
        assert (rsp_cnt == cmd_cnt)
        else
        begin
            fail_cnt++;
            $display("%0d commands but %0d responses", cmd_cnt, rsp_cnt);
        end

        $display("commands %0d, responses %0d, stall cycles %0d, mismatches %0d, failures %0d",
                 cmd_cnt, rsp_cnt, stall_cycles, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/periph_bus_pkg.sv
hw/periph_map_pkg.sv
hw/boot_ram.sv
hw/cmd_queue.sv
hw/host_port.sv
hw/periph_targets.sv
hw/periph_subsys.sv
tests/tb_periph_subsys.sv

// ==== Makefile ====
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_subsys
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED
FAIL_MSG  ?= Result: FAILED

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
